// ==== execute_unit.sv ====
`default_nettype none

`include "lc3b_defs.svh"

module execute_unit
(
    input wire logic clk,
    input wire logic rst_n,
    fetch_if.consumer in,
    output logic redirect,
    output lc3b_pkg::word_t redirect_pc,
    output logic train_valid,
    output lc3b_pkg::bht_idx_t train_idx,
    output logic train_taken,
    output logic wb_valid,
    output lc3b_pkg::reg_t wb_reg,
    output lc3b_pkg::word_t wb_data,
    output logic br_valid,
    output logic br_taken,
    output logic br_mispredict
);

    lc3b_pkg::word_t regs [8];
    lc3b_pkg::nzp_t cc;

    lc3b_pkg::instr_u ins;
    lc3b_pkg::word_t src_a;
    lc3b_pkg::word_t src_b;
    lc3b_pkg::word_t imm5_sext;
    lc3b_pkg::word_t pc_plus2;
    lc3b_pkg::word_t off_target; // pc+2 plus offset9 << 1, LEA and BR
    lc3b_pkg::word_t result;
    lc3b_pkg::nzp_t result_cc;
    logic is_write;
    logic is_br;
    logic taken;

    assign in.ready = 1'b1; // single cycle, never stalls

    always_comb
    begin
        ins = lc3b_pkg::instr_u'(in.instr);
        src_a = regs[ins.oper.sr1];
        imm5_sext = {{(`LC3B_WORD_W-5){ins.oper.src2[4]}}, ins.oper.src2};
        src_b = ins.oper.imm ? imm5_sext : regs[ins.oper.src2[2:0]];
        pc_plus2 = in.pc + lc3b_pkg::word_t'(2);
        off_target = pc_plus2 + {{(`LC3B_WORD_W-10){ins.br.offset9[8]}}, ins.br.offset9, 1'b0};

        is_write = 1'b1;
        case (ins.oper.opcode)
            `LC3B_OP_ADD: result = src_a + src_b;
            `LC3B_OP_AND: result = src_a & src_b;
            `LC3B_OP_NOT: result = ~src_a;
            `LC3B_OP_LEA: result = off_target;
            default:
            begin
                result = src_a;
                is_write = 1'b0;
            end
        endcase

        if (result[`LC3B_WORD_W-1])
            result_cc = 3'b100;
        else if (result == '0)
            result_cc = 3'b010;
        else
            result_cc = 3'b001;

        // same word read through the branch view
        is_br = (ins.br.opcode == `LC3B_OP_BR);
        taken = |(ins.br.nzp & cc);
    end

    assign redirect = in.valid && is_br && (taken != in.pred_taken);
    assign redirect_pc = taken ? off_target : pc_plus2;
    assign train_valid = in.valid && is_br;
    assign train_idx = in.pred_idx;
    assign train_taken = taken;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
            cc <= 3'b010; // Z
            wb_valid <= 1'b0;
            br_valid <= 1'b0;
            br_mispredict <= 1'b0;
        end
        else
        begin
            wb_valid <= in.valid && is_write;
            br_valid <= train_valid;
            br_mispredict <= redirect;
            if (in.valid && is_write)
            begin
                regs[ins.oper.dr] <= result;
                cc <= result_cc; // LEA sets codes too
            end
        end
    end

    always_ff @(posedge clk)
    begin
        wb_reg <= ins.oper.dr;
        wb_data <= result;
        br_taken <= taken;
    end

endmodule : execute_unit

`default_nettype wire

// ==== fetch_if.sv ====
`default_nettype none

// one fetched instruction in flight
interface fetch_if;
    logic valid;
    logic ready;
    lc3b_pkg::word_t instr;
    lc3b_pkg::word_t pc; // address of instr
    logic pred_taken;
    lc3b_pkg::bht_idx_t pred_idx; // counter used for the prediction

    modport producer
    (
        output valid, instr, pc, pred_taken, pred_idx,
        input ready
    );

    modport consumer
    (
        input valid, instr, pc, pred_taken, pred_idx,
        output ready
    );
endinterface : fetch_if

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

`include "lc3b_defs.svh"

module fetch_unit
(
    input wire logic clk,
    input wire logic rst_n,
    input wire lc3b_pkg::word_t instr_rdata,
    input wire logic instr_resp,
    input wire logic redirect,
    input wire lc3b_pkg::word_t redirect_pc,
    input wire logic train_valid,
    input wire lc3b_pkg::bht_idx_t train_idx,
    input wire logic train_taken,
    output logic instr_req,
    output lc3b_pkg::word_t instr_addr,
    fetch_if.producer out
);

    localparam int BHT_SIZE = 1 << `LC3B_BHT_BITS;

    lc3b_pkg::word_t fetch_pc; // next address to request
    lc3b_pkg::word_t req_addr; // address of the outstanding request
    logic req_active;
    logic discard; // response belongs to a redirected path
    lc3b_pkg::bht_idx_t history;
    logic [1:0] counters [BHT_SIZE];

    lc3b_pkg::instr_u resp;
    lc3b_pkg::bht_idx_t idx;
    lc3b_pkg::word_t pc_plus2;
    lc3b_pkg::word_t target;
    logic predict;
    logic capture;
    logic start;
    logic out_xfer;

    always_comb
    begin
        resp = lc3b_pkg::instr_u'(instr_rdata);
        idx = req_addr[`LC3B_BHT_BITS:1] ^ history; // gshare index
        pc_plus2 = req_addr + lc3b_pkg::word_t'(2);
        target = pc_plus2 + {{(`LC3B_WORD_W-10){resp.br.offset9[8]}}, resp.br.offset9, 1'b0};
        predict = (resp.br.opcode == `LC3B_OP_BR) && counters[idx][1];
        out_xfer = out.valid && out.ready;
        capture = req_active && instr_resp && !discard && !redirect;
        // one request at a time, and only once the offered word is gone
        start = !req_active && (!out.valid || out_xfer) && !redirect;
    end

    assign instr_req = req_active;
    assign instr_addr = req_addr;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fetch_pc <= `LC3B_RESET_PC;
            req_active <= 1'b0;
            discard <= 1'b0;
            out.valid <= 1'b0;
        end
        else
        begin
            if (req_active && instr_resp)
                req_active <= 1'b0;
            else if (start)
                req_active <= 1'b1;

            if (req_active && instr_resp)
                discard <= 1'b0;
            else if (req_active && redirect)
                discard <= 1'b1; // cannot retract the request, drop its data

            if (redirect)
                fetch_pc <= redirect_pc;
            else if (capture)
                fetch_pc <= predict ? target : pc_plus2;

            if (redirect)
                out.valid <= 1'b0; // wrong path entry
            else if (capture)
                out.valid <= 1'b1;
            else if (out_xfer)
                out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            req_addr <= fetch_pc;
        if (capture)
        begin
            out.instr <= instr_rdata;
            out.pc <= req_addr;
            out.pred_taken <= predict;
            out.pred_idx <= idx;
        end
    end

    // counters trained at resolution in execute
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            history <= '0;
            for (int i = 0; i < BHT_SIZE; i++)
                counters[i] <= 2'b01; // weakly not taken
        end
        else if (train_valid)
        begin
            history <= {history[`LC3B_BHT_BITS-2:0], train_taken};
            if (train_taken && counters[train_idx] != 2'b11)
                counters[train_idx] <= counters[train_idx] + 2'd1;
            else if (!train_taken && counters[train_idx] != 2'b00)
                counters[train_idx] <= counters[train_idx] - 2'd1;
        end
    end

endmodule : fetch_unit

`default_nettype wire

// ==== files.f ====
+incdir+.
lc3b_pkg.sv
fetch_if.sv
fetch_unit.sv
instr_queue.sv
execute_unit.sv
lc3b_core.sv
lc3b_core_asserts.sv
tb_lc3b_core.sv

// ==== instr_queue.sv ====
`default_nettype none

`include "lc3b_defs.svh"

module instr_queue
(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic flush,
    fetch_if.consumer in,
    fetch_if.producer out
);

    localparam int DEPTH = `LC3B_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    lc3b_pkg::word_t instr_mem [DEPTH];
    lc3b_pkg::word_t pc_mem [DEPTH];
    logic pred_mem [DEPTH];
    lc3b_pkg::bht_idx_t idx_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign in.ready = (count != CNT_W'(DEPTH)); // full holds fetch
    assign out.valid = (count != '0);
    assign out.instr = instr_mem[rd_ptr];
    assign out.pc = pc_mem[rd_ptr];
    assign out.pred_taken = pred_mem[rd_ptr];
    assign out.pred_idx = idx_mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop = out.valid && out.ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0; // everything queued is wrong path
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push && !flush)
        begin
            instr_mem[wr_ptr] <= in.instr;
            pc_mem[wr_ptr] <= in.pc;
            pred_mem[wr_ptr] <= in.pred_taken;
            idx_mem[wr_ptr] <= in.pred_idx;
        end
    end

endmodule : instr_queue

`default_nettype wire

// ==== lc3b_core.sv ====
`default_nettype none

module lc3b_core
(
    input wire logic clk,
    input wire logic rst_n,
    input wire lc3b_pkg::word_t instr_rdata,
    input wire logic instr_resp,
    output logic instr_req,
    output lc3b_pkg::word_t instr_addr,
    output logic wb_valid,
    output lc3b_pkg::reg_t wb_reg,
    output lc3b_pkg::word_t wb_data,
    output logic br_valid,
    output logic br_taken,
    output logic br_mispredict
);

    logic redirect; // also flushes the queue
    lc3b_pkg::word_t redirect_pc;
    logic train_valid;
    lc3b_pkg::bht_idx_t train_idx;
    logic train_taken;

    fetch_if fetch_q ();
    fetch_if q_exec ();

    fetch_unit fetch_unit_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .instr_rdata(instr_rdata),
        .instr_resp(instr_resp),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .train_valid(train_valid),
        .train_idx(train_idx),
        .train_taken(train_taken),
        .instr_req(instr_req),
        .instr_addr(instr_addr),
        .out(fetch_q.producer)
    );

    instr_queue instr_queue_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .flush(redirect),
        .in(fetch_q.consumer),
        .out(q_exec.producer)
    );

    execute_unit execute_unit_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .in(q_exec.consumer),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .train_valid(train_valid),
        .train_idx(train_idx),
        .train_taken(train_taken),
        .wb_valid(wb_valid),
        .wb_reg(wb_reg),
        .wb_data(wb_data),
        .br_valid(br_valid),
        .br_taken(br_taken),
        .br_mispredict(br_mispredict)
    );

endmodule : lc3b_core

`default_nettype wire

// ==== lc3b_core_asserts.sv ====
`default_nettype none

module lc3b_core_asserts
(
    input wire logic clk,
    input wire logic rst_n,
    input wire logic instr_req,
    input wire lc3b_pkg::word_t instr_addr,
    input wire logic instr_resp,
    input wire logic wb_valid,
    input wire logic br_valid,
    input wire logic br_mispredict
);
    timeunit 1ns;
    timeprecision 100ps;

    // request held with a fixed address until answered
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && !instr_resp |=> instr_req && $stable(instr_addr))
        else $error("instruction request dropped or address changed before the response");

    // one outstanding request, a new one starts only after a gap
    req_single: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req && instr_resp |=> !instr_req)
        else $error("new instruction request started while the previous one was completing");

    outputs_in_reset: assert property (@(posedge clk)
        !rst_n |-> !wb_valid && !br_valid && !br_mispredict)
        else $error("result valid raised during reset");

    outputs_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_valid && !br_valid && !br_mispredict && !instr_req)
        else $error("output active in the first cycle after reset");

    mispredict_is_branch: assert property (@(posedge clk) disable iff (!rst_n)
        br_mispredict |-> br_valid)
        else $error("br_mispredict raised without br_valid");

endmodule : lc3b_core_asserts

bind lc3b_core lc3b_core_asserts lc3b_core_asserts_inst
(
    .clk(clk),
    .rst_n(rst_n),
    .instr_req(instr_req),
    .instr_addr(instr_addr),
    .instr_resp(instr_resp),
    .wb_valid(wb_valid),
    .br_valid(br_valid),
    .br_mispredict(br_mispredict)
);

`default_nettype wire

// ==== lc3b_defs.svh ====
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// datapath sizes
`define LC3B_WORD_W 16 // data and address width

// instruction queue
`define LC3B_QUEUE_DEPTH 4 // entries, power of two

// branch predictor
// index width and global history length, 32 counters
`define LC3B_BHT_BITS 5

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// opcodes, instr[15:12]
`define LC3B_OP_BR 4'b0000
`define LC3B_OP_ADD 4'b0001
`define LC3B_OP_AND 4'b0101
`define LC3B_OP_NOT 4'b1001
`define LC3B_OP_LEA 4'b1110

`endif

// ==== lc3b_pkg.sv ====
`default_nettype none

`include "lc3b_defs.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] word_t;

    typedef logic [2:0] reg_t; // r0..r7

    typedef logic [2:0] nzp_t; // n in bit 2, p in bit 0

    typedef logic [`LC3B_BHT_BITS-1:0] bht_idx_t;

    // ADD, AND, NOT, LEA field layout
    typedef struct packed
    {
        logic [3:0] opcode;
        reg_t dr;
        reg_t sr1;
        logic imm; // 1 selects imm5
        logic [4:0] src2; // imm5, or sr2 in [2:0]
    } oper_t;

    // BR field layout, offset9 also used by LEA
    typedef struct packed
    {
        logic [3:0] opcode;
        nzp_t nzp;
        logic [8:0] offset9;
    } br_t;

    // one instruction word, two views
    typedef union packed
    {
        oper_t oper;
        br_t br;
    } instr_u;

endpackage : lc3b_pkg

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lc3b_core -f files.f > build.log 2>&1 \
    && ./obj_dir/Vtb_lc3b_core > sim.log 2>&1
grep -qs "^Simulation PASSED$" sim.log && echo "run ok" \
    || { echo "run failed, see build.log and sim.log"; exit 1; }

// ==== tb_lc3b_core.sv ====
`default_nettype none

`include "lc3b_defs.svh"

module tb_lc3b_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN = 19;
    localparam int LOOP_ITERS = 20;
    localparam int EXEC_COUNT = 6 + LOOP_ITERS * 8 + 4; // prefix, loop body, tail
    localparam int MAX_CYCLES = 8 * EXEC_COUNT;
    localparam logic [15:0] LOOP_BR_PC = 16'd28;
    localparam logic [15:0] HALT_PC = 16'd36;

    logic clk = 1'b0;
    logic rst_n;
    lc3b_pkg::word_t instr_rdata;
    logic instr_resp;
    logic instr_req;
    lc3b_pkg::word_t instr_addr;
    logic wb_valid;
    lc3b_pkg::reg_t wb_reg;
    lc3b_pkg::word_t wb_data;
    logic br_valid;
    logic br_taken;
    logic br_mispredict;

    logic [15:0] prog [PROG_LEN];
    logic [31:0] rand_state = 32'h3265688a;
    logic [31:0] rnd;
    logic busy = 1'b0; // memory has a request in progress
    logic [1:0] wait_cnt;

    // reference machine state
    logic [15:0] g_reg [8];
    logic [2:0] g_cc;
    logic [15:0] g_pc;
    logic g_is_br;
    logic [2:0] g_dst;
    logic [15:0] g_value;
    logic g_taken;
    logic [15:0] g_at;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int loop_misses = 0;
    logic done = 1'b0;

    lc3b_core lc3b_core_inst
    (
        .clk(clk),
        .rst_n(rst_n),
        .instr_rdata(instr_rdata),
        .instr_resp(instr_resp),
        .instr_req(instr_req),
        .instr_addr(instr_addr),
        .wb_valid(wb_valid),
        .wb_reg(wb_reg),
        .wb_data(wb_data),
        .br_valid(br_valid),
        .br_taken(br_taken),
        .br_mispredict(br_mispredict)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
        cycles = cycles + 1;

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [15:0] enc_imm(input logic [3:0] op, input int dr, input int sr1,
                                            input int imm);
        return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic logic [15:0] enc_reg(input logic [3:0] op, input int dr, input int sr1,
                                            input int sr2);
        return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic logic [15:0] enc_not(input int dr, input int sr);
        return {`LC3B_OP_NOT, dr[2:0], sr[2:0], 6'b111111};
    endfunction

    function automatic logic [15:0] enc_lea(input int dr, input int off);
        return {`LC3B_OP_LEA, dr[2:0], off[8:0]};
    endfunction

    function automatic logic [15:0] enc_br(input logic [2:0] nzp, input int off);
        return {`LC3B_OP_BR, nzp, off[8:0]};
    endfunction

    // outside the program a never-taken branch, offset from every address bit
    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        int idx;
        idx = int'(addr[15:1]);
        if (idx < PROG_LEN)
            return prog[idx];
        return {`LC3B_OP_BR, 3'b000, addr[8:0] ^ addr[15:7]};
    endfunction

    task automatic load_program();
        prog[0] = enc_imm(`LC3B_OP_AND, 1, 1, 0);
        prog[1] = enc_imm(`LC3B_OP_ADD, 1, 1, 10);
        prog[2] = enc_imm(`LC3B_OP_ADD, 1, 1, 10); // r1 = loop count
        prog[3] = enc_imm(`LC3B_OP_AND, 2, 2, 0);
        prog[4] = enc_br(3'b010, 1); // taken, skips the next word
        prog[5] = enc_imm(`LC3B_OP_ADD, 7, 7, 15); // wrong path only
        prog[6] = enc_lea(6, -3);
        prog[7] = enc_imm(`LC3B_OP_ADD, 2, 2, 3); // loop head
        prog[8] = enc_reg(`LC3B_OP_ADD, 3, 2, 1);
        prog[9] = enc_imm(`LC3B_OP_AND, 4, 3, -11);
        prog[10] = enc_not(5, 3);
        prog[11] = enc_reg(`LC3B_OP_AND, 0, 5, 2);
        prog[12] = enc_lea(6, -6);
        prog[13] = enc_imm(`LC3B_OP_ADD, 1, 1, -1);
        prog[14] = enc_br(3'b001, -8); // backward loop branch
        prog[15] = enc_br(3'b100, 2); // never taken here
        prog[16] = enc_imm(`LC3B_OP_ADD, 7, 7, -16);
        prog[17] = enc_not(7, 7);
        prog[18] = enc_br(3'b111, -1); // spins on itself
    endtask

    // one instruction of the reference machine
    task automatic step_golden();
        logic [15:0] ir;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] off;
        ir = fetch_word(g_pc);
        g_at = g_pc;
        a = g_reg[ir[8:6]];
        b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : g_reg[ir[2:0]];
        off = {{6{ir[8]}}, ir[8:0], 1'b0};
        g_is_br = (ir[15:12] == `LC3B_OP_BR);
        g_dst = ir[11:9];
        g_taken = |(ir[11:9] & g_cc);
        case (ir[15:12])
            `LC3B_OP_ADD: g_value = a + b;
            `LC3B_OP_AND: g_value = a & b;
            `LC3B_OP_NOT: g_value = ~a;
            default: g_value = g_pc + 16'd2 + off; // LEA
        endcase
        if (g_is_br)
            g_pc = g_taken ? g_pc + 16'd2 + off : g_pc + 16'd2;
        else
        begin
            g_reg[g_dst] = g_value;
            g_cc = g_value[15] ? 3'b100 : (g_value == 16'd0 ? 3'b010 : 3'b001);
            g_pc = g_pc + 16'd2;
        end
    endtask

    task automatic count_mismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
        errors++;
        $display("mismatch %s at pc %h: expected %h, actual %h", name, g_at, expected, actual);
    endtask

    task automatic fail_check(input string what);
        errors++;
        $display("%s", what);
    endtask

    // memory model, latency 1 to 4 cycles
    always @(posedge clk)
    begin
        #1;
        if (!rst_n)
        begin
            instr_resp = 1'b0;
            busy = 1'b0;
        end
        else if (instr_resp)
        begin
            instr_resp = 1'b0;
            busy = 1'b0;
        end
        else
        begin
            if (instr_req && !busy)
            begin
                busy = 1'b1;
                rnd = next_random();
                wait_cnt = rnd[17:16];
            end
            if (busy && wait_cnt == 2'd0)
            begin
                instr_resp = 1'b1;
                instr_rdata = fetch_word(instr_addr);
            end
            else if (busy)
                wait_cnt = wait_cnt - 2'd1;
        end
    end

    // outputs are registered, so compare away from the rising edge
    always @(negedge clk)
    begin
        if (rst_n && !done && (wb_valid || br_valid))
        begin
            step_golden();
            checks++;
            assert (!(wb_valid && br_valid))
            else
                fail_check("wb_valid and br_valid were high in the same cycle");
            if (g_is_br)
            begin
                assert (br_valid) else count_mismatch("instruction kind", 16'd1, 16'd0);
                assert (br_taken == g_taken)
                else
                    count_mismatch("branch outcome", {15'd0, g_taken}, {15'd0, br_taken});
                if (g_at == LOOP_BR_PC && br_mispredict)
                    loop_misses++;
                if (g_at == LOOP_BR_PC && !g_taken)
                    assert (br_mispredict) else fail_check("loop exit was not mispredicted");
                if (g_at == HALT_PC)
                    done = 1'b1;
            end
            else
            begin
                assert (wb_valid) else count_mismatch("instruction kind", 16'd0, 16'd1);
                assert (wb_reg == g_dst)
                else
                    count_mismatch("writeback register", {13'd0, g_dst}, {13'd0, wb_reg});
                assert (wb_data == g_value)
                else
                    count_mismatch("writeback data", g_value, wb_data);
            end
        end
    end

    initial
    begin
        rst_n = 1'b0;
        instr_resp = 1'b0;
        instr_rdata = '0;
        load_program();
        for (int i = 0; i < 8; i++)
            g_reg[i] = 16'd0;
        g_cc = 3'b010;
        g_pc = `LC3B_RESET_PC;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        wait (done || cycles >= MAX_CYCLES);
        if (!done)
            fail_check($sformatf("timeout, program not finished after %0d cycles", cycles));
        else
            assert (loop_misses <= 8)
            else
                fail_check($sformatf("loop branch mispredicted %0d times", loop_misses));

        $display("checks %0d, errors %0d, loop mispredicts %0d, cycles %0d",
                 checks, errors, loop_misses, cycles);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule : tb_lc3b_core

`default_nettype wire
